// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_top
FILELIST = project.f
OBJDIR   = obj_dir
PASS     = ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf $(OBJDIR)

// File: project.f
verilog/soc_bus_pkg.sv
verilog/request_decoder.sv
verilog/sram_bank.sv
verilog/response_arbiter.sv
verilog/mem_subsystem_top.sv
verif/tb_top.sv

// File: verif/tb_top.sv
`default_nettype none

module tb_top
    import soc_bus_pkg::*;
();

    localparam int clk_period   = 10;
    localparam int bp_reads     = 12;
    localparam int hold_cycles  = 40;
    localparam int fill_words   = 32;
    localparam int random_reqs  = 200;
    localparam int total_reqs   = 8 + 6 + 8 + bp_reads + fill_words + random_reqs;
    localparam int per_req_cyc  = 40;
    localparam int watchdog_cyc = total_reqs * per_req_cyc + hold_cycles + 100;
    localparam logic [31:0] lfsr_seed = 32'h730851fe;
    localparam logic [31:0] lfsr_taps = 32'h80200003;

    logic     clk;
    logic     rst;
    logic     req_valid;
    bus_req_t req;
    logic     req_credit;
    logic     rsp_valid;
    bus_rsp_t rsp;
    logic     rsp_credit;

    logic [data_w-1:0] ref_mem [2**addr_w];
    bus_rsp_t          exp_rsp [2**id_w];
    bank_idx_t         exp_bank [2**id_w];
    int                exp_seq [2**id_w];
    int                id_issued [2**id_w];
    int                id_done [2**id_w];
    int                bank_issued [num_banks];
    int                bank_done [num_banks];
    int                credits_used;
    int                credits_back;
    int                rsp_seen;
    int                credits_returned;
    int                rsp_errors;
    int                count_errors;
    int                tests_run;
    int                tests_failed;
    logic              hold_rsp;
    logic [31:0]       lfsr_state;
    logic [id_w-1:0]   next_id;

    mem_subsystem_top mem_subsystem_top_inst (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .req_credit (req_credit),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .rsp_credit (rsp_credit)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Every address bit shows up in every byte
    function automatic logic [data_w-1:0] fill_word(input logic [addr_w-1:0] a);
        return {a, ~a, a ^ 8'h5a, a + 8'h3c};
    endfunction

    function automatic logic id_busy(input logic [id_w-1:0] id);
        return id_issued[id] != id_done[id];
    endfunction

    function automatic int outstanding();
        int n;
        n = 0;
        for (int i = 0; i < 2**id_w; i++) begin
            n += id_issued[i] - id_done[i];
        end
        return n;
    endfunction

    function automatic int total_errors();
        return rsp_errors + count_errors;
    endfunction

    task automatic compare_rsp(input bus_rsp_t got, input bus_rsp_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: rsp id/write/rdata got %0h/%0b/%h expected %0h/%0b/%h",
                     $time, got.id, got.write, got.rdata, exp.id, exp.write, exp.rdata);
            rsp_errors++;
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            count_errors++;
        end
    endtask

    // Monitor for credits and responses at the falling edge
    initial begin
        bank_idx_t b;
        forever begin
            @(negedge clk);
            if (req_credit) begin
                credits_back++;
                if (credits_back > credits_used) begin
                    $display("Error at %0t: request credit returned beyond the credits spent",
                             $time);
                    rsp_errors++;
                end
            end
            if (rsp_valid) begin
                rsp_seen++;
                if (!id_busy(rsp.id)) begin
                    $display("Error at %0t: response id %0h is not outstanding", $time, rsp.id);
                    rsp_errors++;
                end else begin
                    compare_rsp(rsp, exp_rsp[rsp.id]);
                    b = exp_bank[rsp.id];
                    if (exp_seq[rsp.id] != bank_done[b]) begin
                        $display("Error at %0t: bank %0d answered id %0h out of order",
                                 $time, b, rsp.id);
                        rsp_errors++;
                    end
                    bank_done[b]++;
                    id_done[rsp.id]++;
                end
            end
        end
    end

    // Master hands one credit back per response unless held
    initial begin
        rsp_credit = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            rsp_credit = !hold_rsp && (rsp_seen > credits_returned);
            if (rsp_credit) begin
                credits_returned++;
            end
        end
    end

    initial begin
        #(watchdog_cyc * clk_period);
        $display("Timeout at %0t: traffic did not complete in time", $time);
        $display("SOME TESTS FAILED");
        $finish;
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic issue(input bus_req_t r);
        logic [addr_w-1:0] a;
        bank_idx_t         b;
        a = r.addr;
        b = a[addr_w-1 -: bank_sel_w];
        while (credits_used - credits_back >= in_depth) begin
            req_valid = 1'b0;
            next_cycle();
        end
        if (r.write) begin
            for (int i = 0; i < strb_w; i++) begin
                if (r.strb[i]) begin
                    ref_mem[a][i*8 +: 8] = r.wdata[i*8 +: 8];
                end
            end
            exp_rsp[r.id] = '{id: r.id, write: 1'b1, rdata: '0};
        end else begin
            exp_rsp[r.id] = '{id: r.id, write: 1'b0, rdata: ref_mem[a]};
        end
        exp_bank[r.id] = b;
        exp_seq[r.id] = bank_issued[b];
        bank_issued[b]++;
        id_issued[r.id]++;
        credits_used++;
        req_valid = 1'b1;
        req = r;
        next_cycle();
        req_valid = 1'b0;
    endtask

    // First id at or after next_id that is not in flight
    task automatic send(input logic write, input logic [addr_w-1:0] addr,
                        input logic [data_w-1:0] wdata, input logic [strb_w-1:0] strb);
        bus_req_t        r;
        logic [id_w-1:0] id;
        while (outstanding() >= 2**id_w) begin
            next_cycle();
        end
        id = next_id;
        while (id_busy(id)) begin
            id++;
        end
        next_id = id + 1'b1;
        r = '{id: id, write: write, addr: addr, wdata: wdata, strb: strb};
        issue(r);
    endtask

    task automatic wait_idle();
        while (outstanding() != 0 || rsp_seen != credits_returned) begin
            next_cycle();
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        int errs;
        compare_count("request credits outstanding", credits_used - credits_back, 0);
        errs = total_errors() - errs_before;
        tests_run++;
        if (errs == 0) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errs);
        end
    endtask

    task automatic test_write_read();
        int                e0;
        logic [addr_w-1:0] a;
        e0 = total_errors();
        for (int b = 0; b < num_banks; b++) begin
            a = addr_w'(b * bank_words + 3 + b * 7);
            send(1'b1, a, rand_bits(data_w), '1);
            send(1'b0, a, '0, '0);
        end
        wait_idle();
        finish_test("write_read", e0);
    endtask

    task automatic test_strobe();
        int                e0;
        logic [addr_w-1:0] a;
        e0 = total_errors();
        a = addr_w'(1 * bank_words + 10);
        send(1'b1, a, 32'h11223344, 4'hf);
        send(1'b1, a, 32'haabbccdd, 4'b0101);
        send(1'b0, a, '0, '0);
        a = addr_w'(3 * bank_words + 41);
        send(1'b1, a, 32'h55667788, 4'hf);
        send(1'b1, a, 32'h99eeff00, 4'b1010);
        send(1'b0, a, '0, '0);
        wait_idle();
        finish_test("strobe", e0);
    endtask

    // Same offset in each bank with distinct data
    task automatic test_bank_decode();
        int e0;
        e0 = total_errors();
        for (int b = 0; b < num_banks; b++) begin
            send(1'b1, addr_w'(b * bank_words + 21), 32'hb0b00000 + data_w'(b * 32'h111), '1);
        end
        for (int b = 0; b < num_banks; b++) begin
            send(1'b0, addr_w'(b * bank_words + 21), '0, '0);
        end
        wait_idle();
        finish_test("bank_decode", e0);
    endtask

    task automatic test_backpressure();
        int e0;
        int base;
        e0 = total_errors();
        base = rsp_seen;
        hold_rsp = 1'b1;
        for (int i = 0; i < bp_reads; i++) begin
            send(1'b0, addr_w'((i % num_banks) * bank_words + 21), '0, '0);
        end
        repeat (hold_cycles) next_cycle();
        compare_count("responses while held", rsp_seen - base, rsp_credits);
        hold_rsp = 1'b0;
        wait_idle();
        compare_count("responses after release", rsp_seen - base, bp_reads);
        finish_test("backpressure", e0);
    endtask

    task automatic test_random();
        int                e0;
        logic [addr_w-1:0] a;
        logic              wr;
        e0 = total_errors();
        for (int b = 0; b < num_banks; b++) begin
            for (int o = 0; o < fill_words / num_banks; o++) begin
                a = addr_w'(b * bank_words + o);
                send(1'b1, a, fill_word(a), '1);
            end
        end
        for (int i = 0; i < random_reqs; i++) begin
            a = addr_w'(rand_bits(bank_sel_w) * bank_words + rand_bits(3));
            wr = rand_bits(1) != 0;
            next_id = id_w'(rand_bits(id_w));
            if (wr) begin
                send(1'b1, a, rand_bits(data_w), strb_w'(rand_bits(strb_w)));
            end else begin
                send(1'b0, a, '0, '0);
            end
        end
        wait_idle();
        finish_test("random", e0);
    endtask

    initial begin
        rst = 1'b1;
        req_valid = 1'b0;
        req = '0;
        hold_rsp = 1'b0;
        lfsr_state = lfsr_seed;
        next_id = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        compare_count("req_credit after reset", int'(req_credit), 0);
        compare_count("rsp_valid after reset", int'(rsp_valid), 0);
        next_cycle();
        test_write_read();
        test_strobe();
        test_bank_decode();
        test_backpressure();
        test_random();
        $display("tests run %0d, failed %0d, errors %0d",
                 tests_run, tests_failed, total_errors());
        if (total_errors() == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/mem_subsystem_top.sv
`default_nettype none

module mem_subsystem_top
    import soc_bus_pkg::*;
(
    input  wire           clk,
    input  wire           rst,
    input  wire           req_valid,
    input  wire bus_req_t req,
    output logic          req_credit,
    output logic          rsp_valid,
    output bus_rsp_t      rsp,
    input  wire           rsp_credit
);

    logic [num_banks-1:0] bank_req_valid;
    bus_req_t             bank_req;
    logic [num_banks-1:0] bank_credit;
    logic [num_banks-1:0] rsp_valid_out;
    bus_rsp_t             bank_rsp [num_banks];
    logic [num_banks-1:0] rsp_take;

    request_decoder request_decoder_inst (
        .clk            (clk),
        .rst            (rst),
        .req_valid      (req_valid),
        .req            (req),
        .req_credit     (req_credit),
        .bank_req_valid (bank_req_valid),
        .bank_req       (bank_req),
        .bank_credit    (bank_credit)
    );

    // All banks share the request bus and a valid bit picks one
    for (genvar i = 0; i < num_banks; i++) begin : g_bank
        sram_bank sram_bank_inst (
            .clk            (clk),
            .rst            (rst),
            .bank_req_valid (bank_req_valid[i]),
            .bank_req       (bank_req),
            .bank_credit    (bank_credit[i]),
            .rsp_valid_out  (rsp_valid_out[i]),
            .rsp_out        (bank_rsp[i]),
            .rsp_take       (rsp_take[i])
        );
    end

    response_arbiter response_arbiter_inst (
        .clk           (clk),
        .rst           (rst),
        .rsp_valid_out (rsp_valid_out),
        .rsp_out       (bank_rsp),
        .rsp_take      (rsp_take),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .rsp_credit    (rsp_credit)
    );

endmodule

`default_nettype wire

// File: verilog/request_decoder.sv
`default_nettype none

module request_decoder
    import soc_bus_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      req_valid,
    input  wire bus_req_t            req,
    output logic                     req_credit,
    output logic [num_banks-1:0]     bank_req_valid,
    output bus_req_t                 bank_req,
    input  wire  [num_banks-1:0]     bank_credit
);

    bus_req_t              fifo [in_depth];
    logic [in_ptr_w-1:0]   wr_ptr;
    logic [in_ptr_w-1:0]   rd_ptr;
    logic [in_cnt_w-1:0]   fill;
    logic [bank_cnt_w-1:0] bank_cnt [num_banks];

    bus_req_t  head;
    bank_idx_t head_bank;
    logic      send;

    assign head      = fifo[rd_ptr];
    assign head_bank = head.addr[addr_w-1 -: bank_sel_w];

    // Forward only if the target bank still has queue space
    assign send     = (fill != '0) && (bank_cnt[head_bank] != '0);
    assign bank_req = head;

    always_comb begin
        bank_req_valid = '0;
        bank_req_valid[head_bank] = send;
    end

    // Master credits cover the queue depth
    always_ff @(posedge clk) begin
        if (req_valid) begin
            fifo[wr_ptr] <= req;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill       <= '0;
            req_credit <= 1'b0;
        end else begin
            if (req_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            fill       <= fill + in_cnt_w'(req_valid) - in_cnt_w'(send);
            req_credit <= send;
        end
    end

    // Per-bank credits come back when the bank pops its queue
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < num_banks; i++) begin
                bank_cnt[i] <= bank_cnt_w'(bank_depth);
            end
        end else begin
            for (int i = 0; i < num_banks; i++) begin
                if (bank_credit[i] && !bank_req_valid[i]) begin
                    bank_cnt[i] <= bank_cnt[i] + 1'b1;
                end else if (!bank_credit[i] && bank_req_valid[i]) begin
                    bank_cnt[i] <= bank_cnt[i] - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/response_arbiter.sv
`default_nettype none

module response_arbiter
    import soc_bus_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst,
    input  wire [num_banks-1:0]  rsp_valid_out,
    input  wire bus_rsp_t        rsp_out [num_banks],
    output logic [num_banks-1:0] rsp_take,
    output logic                 rsp_valid,
    output bus_rsp_t             rsp,
    input  wire                  rsp_credit
);

    logic [rsp_cnt_w-1:0] credit_cnt;
    bank_idx_t            last;
    bank_idx_t            pick;
    logic                 found;
    logic                 fire;

    // Search starts one past the previous winner
    always_comb begin
        bank_idx_t idx;
        found = 1'b0;
        pick  = last;
        for (int k = 1; k <= num_banks; k++) begin
            idx = last + bank_idx_t'(k);
            if (!found && rsp_valid_out[idx]) begin
                found = 1'b1;
                pick  = idx;
            end
        end
    end

    assign fire = found && (credit_cnt != '0);

    always_comb begin
        rsp_take = '0;
        rsp_take[pick] = fire;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credit_cnt <= rsp_cnt_w'(rsp_credits);
            last       <= bank_idx_t'(num_banks - 1);
            rsp_valid  <= 1'b0;
        end else begin
            credit_cnt <= credit_cnt + rsp_cnt_w'(rsp_credit) - rsp_cnt_w'(fire);
            if (fire) begin
                last <= pick;
            end
            rsp_valid <= fire;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            rsp <= rsp_out[pick];
        end
    end

endmodule

`default_nettype wire

// File: verilog/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

    // Data path
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;
    localparam int id_w   = 4;

    // Bank geometry with the bank index in the upper address bits
    localparam int num_banks  = 4;
    localparam int bank_sel_w = 2;
    localparam int bank_words = 64;
    localparam int offset_w   = 6;
    localparam int addr_w     = bank_sel_w + offset_w;

    // Queue depths double as the initial credit counts
    localparam int in_depth    = 4;
    localparam int bank_depth  = 2;
    localparam int rsp_credits = 4;

    // Pointer and counter widths derived from the depths
    localparam int in_ptr_w   = $clog2(in_depth);
    localparam int in_cnt_w   = $clog2(in_depth + 1);
    localparam int bank_ptr_w = $clog2(bank_depth);
    localparam int bank_cnt_w = $clog2(bank_depth + 1);
    localparam int rsp_cnt_w  = $clog2(rsp_credits + 1);

    typedef logic [bank_sel_w-1:0] bank_idx_t;

    // One-word request where reads ignore wdata and strb
    typedef struct packed {
        logic [id_w-1:0]   id;
        logic              write;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
        logic [strb_w-1:0] strb;
    } bus_req_t;

    // Response with zero rdata for writes
    typedef struct packed {
        logic [id_w-1:0]   id;
        logic              write;
        logic [data_w-1:0] rdata;
    } bus_rsp_t;

endpackage

`default_nettype wire

// File: verilog/sram_bank.sv
`default_nettype none

module sram_bank
    import soc_bus_pkg::*;
(
    input  wire           clk,
    input  wire           rst,
    input  wire           bank_req_valid,
    input  wire bus_req_t bank_req,
    output logic          bank_credit,
    output logic          rsp_valid_out,
    output bus_rsp_t      rsp_out,
    input  wire           rsp_take
);

    bus_req_t              queue [bank_depth];
    logic [bank_ptr_w-1:0] wr_ptr;
    logic [bank_ptr_w-1:0] rd_ptr;
    logic [bank_cnt_w-1:0] fill;
    logic [data_w-1:0]     mem [bank_words];

    bus_req_t            head;
    logic [offset_w-1:0] offset;
    logic                pop;

    assign head   = queue[rd_ptr];
    assign offset = head.addr[offset_w-1:0];

    // Execute only when the response slot is free or drains this cycle
    assign pop         = (fill != '0) && (!rsp_valid_out || rsp_take);
    assign bank_credit = pop;

    always_ff @(posedge clk) begin
        if (bank_req_valid) begin
            queue[wr_ptr] <= bank_req;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            fill          <= '0;
            rsp_valid_out <= 1'b0;
        end else begin
            if (bank_req_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            fill <= fill + bank_cnt_w'(bank_req_valid) - bank_cnt_w'(pop);
            if (pop) begin
                rsp_valid_out <= 1'b1;
            end else if (rsp_take) begin
                rsp_valid_out <= 1'b0;
            end
        end
    end

    // Byte lanes with a clear strobe keep their old value
    always_ff @(posedge clk) begin
        if (pop && head.write) begin
            for (int b = 0; b < strb_w; b++) begin
                if (head.strb[b]) begin
                    mem[offset][b*8 +: 8] <= head.wdata[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            rsp_out.id    <= head.id;
            rsp_out.write <= head.write;
            rsp_out.rdata <= head.write ? '0 : mem[offset];
        end
    end

endmodule

`default_nettype wire
